//--- rtl/sld_pkg.sv
//////////////////////////////////////////////////////////////////////
// vector slide unit shared types
// widths, opcodes and the beat structs passed down the pipeline
//////////////////////////////////////////////////////////////////////
`default_nettype none

package sld_pkg;

    localparam int VREG_W      = 128;
    localparam int SLD_OP_W    = 32;                  // chunk width
    localparam int VREG_BYTES  = VREG_W / 8;
    localparam int CHUNK_BYTES = SLD_OP_W / 8;
    localparam int CHUNK_CNT   = VREG_W / SLD_OP_W;
    localparam int CHUNK_IDX_W = 2;
    localparam int OFFSET_W    = 6;                   // element offset 0..63
    localparam int VL_W        = 5;                   // 0..16 elements
    localparam int BOFS_W      = OFFSET_W + 3;        // signed byte offset up to 63 words

    typedef enum logic [1:0] {
        SLD_UP    = 2'd0,
        SLD_DOWN  = 2'd1,
        SLD_1UP   = 2'd2,
        SLD_1DOWN = 2'd3
    } sld_op_e;

    typedef enum logic [1:0] {
        EEW_8  = 2'd0,
        EEW_16 = 2'd1,
        EEW_32 = 2'd2
    } sld_eew_e;

    typedef struct packed {
        sld_op_e             op;
        sld_eew_e            eew;
        logic [OFFSET_W-1:0] offset;
        logic [31:0]         scalar;
        logic [VL_W-1:0]     vl;
        logic [VREG_W-1:0]   src;
    } sld_cmd_t;

    typedef struct packed {
        logic [CHUNK_IDX_W-1:0] idx;
        logic [BOFS_W-1:0]      bofs;   // negative for down slides
        logic                   down;
        logic                   slide1;
        sld_eew_e               eew;
        logic [VL_W-1:0]        vl;
        logic [31:0]            scalar;
        logic                   last;
        logic [VREG_W-1:0]      src;
        logic [SLD_OP_W-1:0]    op_hi;
        logic [SLD_OP_W-1:0]    op_lo;
        logic                   hi_vld;
        logic                   lo_vld;
    } sld_beat_t;

    typedef struct packed {
        logic [CHUNK_IDX_W-1:0] idx;
        logic [VL_W-1:0]        vl;
        sld_eew_e               eew;
        logic                   last;
        logic [SLD_OP_W-1:0]    data;
        logic [CHUNK_BYTES-1:0] bvld;
    } sld_chunk_t;

    typedef struct packed {
        logic [VREG_W-1:0]     data;
        logic [VREG_BYTES-1:0] be;
    } sld_result_t;

    // bytes per element
    function automatic logic [2:0] eew_bytes(sld_eew_e eew);
        unique case (eew)
            EEW_16:  return 3'd2;
            EEW_32:  return 3'd4;
            default: return 3'd1;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- rtl/sld_issue.sv
//////////////////////////////////////////////////////////////////////
// slide issue stage
// latches a command and sequences its chunks, one beat per cycle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module sld_issue (
    input  wire logic                 clk_i,
    input  wire logic                 async_rst_ni,
    input  wire logic                 cmd_valid_i,
    input  wire sld_pkg::sld_cmd_t    cmd_i,
    input  wire logic                 beat_ready_i,
    output logic                      cmd_ready_o,
    output logic                      beat_valid_o,
    output sld_pkg::sld_beat_t        beat_o
);

    localparam int BOFS_W      = sld_pkg::BOFS_W;
    localparam int CHUNK_IDX_W = sld_pkg::CHUNK_IDX_W;
    localparam int CHUNK_CNT   = sld_pkg::CHUNK_CNT;

    logic               busy_q;
    sld_pkg::sld_beat_t beat_q;
    sld_pkg::sld_beat_t beat_d;
    logic               accept;
    logic               advance;
    logic               down;
    logic               slide1;
    logic [BOFS_W-1:0]  ofs_bytes;

    // a new command may enter while the last chunk of the previous one leaves
    assign cmd_ready_o = ~busy_q | (beat_q.last & beat_ready_i);
    assign accept      = cmd_valid_i & cmd_ready_o;
    assign advance     = busy_q & beat_ready_i;

    assign down   = (cmd_i.op == sld_pkg::SLD_DOWN) | (cmd_i.op == sld_pkg::SLD_1DOWN);
    assign slide1 = (cmd_i.op == sld_pkg::SLD_1UP) | (cmd_i.op == sld_pkg::SLD_1DOWN);

    ///////////////////////////////////////////////////////////////////
    // element offset to byte offset

    always_comb begin
        if (slide1) begin
            ofs_bytes = BOFS_W'(sld_pkg::eew_bytes(cmd_i.eew)); // always one element
        end else begin
            unique case (cmd_i.eew)
                sld_pkg::EEW_16: ofs_bytes = BOFS_W'(cmd_i.offset) << 1;
                sld_pkg::EEW_32: ofs_bytes = BOFS_W'(cmd_i.offset) << 2;
                default:         ofs_bytes = BOFS_W'(cmd_i.offset);
            endcase
        end
    end

    always_comb begin
        beat_d        = '0;
        beat_d.idx    = '0;
        beat_d.bofs   = down ? -ofs_bytes : ofs_bytes;
        beat_d.down   = down;
        beat_d.slide1 = slide1;
        beat_d.eew    = cmd_i.eew;
        beat_d.vl     = cmd_i.vl;
        beat_d.scalar = cmd_i.scalar;
        beat_d.last   = (CHUNK_CNT == 1);
        beat_d.src    = cmd_i.src;
    end

    ///////////////////////////////////////////////////////////////////
    // chunk sequencing

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            busy_q <= 1'b0;
        end else if (accept) begin
            busy_q <= 1'b1;
        end else if (advance && beat_q.last) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            beat_q <= beat_d;
        end else if (advance) begin
            beat_q.idx  <= beat_q.idx + 1'b1;
            beat_q.last <= (beat_q.idx == CHUNK_IDX_W'(CHUNK_CNT - 2)); // next one is the last
        end
    end

    assign beat_valid_o = busy_q;
    assign beat_o       = beat_q;

endmodule

`default_nettype wire

//--- rtl/sld_operand.sv
//////////////////////////////////////////////////////////////////////
// slide operand stage
// picks the source chunk pair for each destination chunk
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module sld_operand (
    input  wire logic                 clk_i,
    input  wire logic                 async_rst_ni,
    input  wire logic                 beat_valid_i,
    input  wire sld_pkg::sld_beat_t   beat_i,
    input  wire logic                 beat_ready_i,
    output logic                      beat_ready_o,
    output logic                      beat_valid_o,
    output sld_pkg::sld_beat_t        beat_o
);

    localparam int SLD_OP_W    = sld_pkg::SLD_OP_W;
    localparam int CHUNK_BYTES = sld_pkg::CHUNK_BYTES;
    localparam int CHUNK_CNT   = sld_pkg::CHUNK_CNT;
    localparam int CHUNK_IDX_W = sld_pkg::CHUNK_IDX_W;
    localparam int IDX_S_W     = sld_pkg::BOFS_W + 1;   // signed chunk index
    localparam int POS_W       = IDX_S_W + 2;           // signed byte position

    logic                       valid_q;
    sld_pkg::sld_beat_t         beat_q;
    sld_pkg::sld_beat_t         beat_d;
    logic signed [IDX_S_W-1:0]  q_chunks;
    logic signed [IDX_S_W-1:0]  sidx [2];   // 0 low, 1 high
    logic                       in_rng [2];
    logic [SLD_OP_W-1:0]        opd [2];
    logic signed [POS_W-1:0]    rel;
    logic [7:0]                 vl_bytes;
    logic [2:0]                 ebytes;
    logic [SLD_OP_W-1:0]        scalar_rep;

    function automatic logic [SLD_OP_W-1:0] rep_scalar(sld_pkg::sld_eew_e eew,
                                                        logic [31:0] s);
        unique case (eew)
            sld_pkg::EEW_16: return {(SLD_OP_W/16){s[15:0]}};
            sld_pkg::EEW_32: return {(SLD_OP_W/32){s}};
            default:         return {(SLD_OP_W/8){s[7:0]}};
        endcase
    endfunction

    always_comb begin
        beat_d     = beat_i;
        ebytes     = sld_pkg::eew_bytes(beat_i.eew);
        vl_bytes   = {3'b0, beat_i.vl} * {5'b0, ebytes};
        scalar_rep = rep_scalar(beat_i.eew, beat_i.scalar);
        rel        = '0;

        // whole chunks of the offset rounded towards minus infinity
        q_chunks = $signed({beat_i.bofs[sld_pkg::BOFS_W-1], beat_i.bofs}) >>> 2;
        sidx[1]  = $signed({{(IDX_S_W-CHUNK_IDX_W){1'b0}}, beat_i.idx}) - q_chunks;
        sidx[0]  = sidx[1] - IDX_S_W'(1);

        for (int j = 0; j < 2; j++) begin
            in_rng[j] = (sidx[j] >= 0) && (sidx[j] < CHUNK_CNT);
            opd[j]    = in_rng[j] ?
                        beat_i.src[sidx[j][CHUNK_IDX_W-1:0]*SLD_OP_W +: SLD_OP_W] : '0;
            if (beat_i.slide1 && !beat_i.down && !in_rng[j]) begin
                opd[j] = scalar_rep;    // fills the vacated element 0
            end
            // slide1down puts the scalar at source element vl so it lands at vl-1
            if (beat_i.slide1 && beat_i.down) begin
                for (int b = 0; b < CHUNK_BYTES; b++) begin
                    rel = (POS_W'(sidx[j]) <<< 2) + POS_W'(b) - $signed({4'b0, vl_bytes});
                    if (rel >= 0 && rel < $signed({{(POS_W-3){1'b0}}, ebytes})) begin
                        opd[j][b*8 +: 8] = beat_i.scalar[rel[1:0]*8 +: 8];
                    end
                end
            end
        end

        beat_d.op_lo  = opd[0];
        beat_d.op_hi  = opd[1];
        beat_d.lo_vld = in_rng[0] | beat_i.down;   // down slides zero fill
        beat_d.hi_vld = in_rng[1] | beat_i.down;
    end

    assign beat_ready_o = ~valid_q | beat_ready_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else if (beat_ready_o) begin
            valid_q <= beat_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (beat_ready_o && beat_valid_i) begin
            beat_q <= beat_d;
        end
    end

    assign beat_valid_o = valid_q;
    assign beat_o       = beat_q;

endmodule

`default_nettype wire

//--- rtl/sld_shift.sv
//////////////////////////////////////////////////////////////////////
// slide byte shifter
// merges the operand pair into one result chunk with byte valids
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module sld_shift (
    input  wire logic                 clk_i,
    input  wire logic                 async_rst_ni,
    input  wire logic                 beat_valid_i,
    input  wire sld_pkg::sld_beat_t   beat_i,
    input  wire logic                 chunk_ready_i,
    output logic                      beat_ready_o,
    output logic                      chunk_valid_o,
    output sld_pkg::sld_chunk_t       chunk_o
);

    localparam int CHUNK_BYTES = sld_pkg::CHUNK_BYTES;

    logic                 valid_q;
    sld_pkg::sld_chunk_t  chunk_q;
    sld_pkg::sld_chunk_t  chunk_d;
    logic [1:0]           r;       // byte offset within a chunk
    logic [1:0]           sel;

    assign r = beat_i.bofs[1:0];

    always_comb begin
        chunk_d      = '0;
        chunk_d.idx  = beat_i.idx;
        chunk_d.vl   = beat_i.vl;
        chunk_d.eew  = beat_i.eew;
        chunk_d.last = beat_i.last;
        sel          = '0;
        for (int k = 0; k < CHUNK_BYTES; k++) begin
            sel = 2'(k) - r;
            if (2'(k) < r) begin
                chunk_d.data[k*8 +: 8] = beat_i.op_lo[sel*8 +: 8];
                chunk_d.bvld[k]        = beat_i.lo_vld;
            end else begin
                chunk_d.data[k*8 +: 8] = beat_i.op_hi[sel*8 +: 8];
                chunk_d.bvld[k]        = beat_i.hi_vld;
            end
        end
        if (beat_i.slide1) begin
            chunk_d.bvld = '1;  // scalar covers the gap
        end
    end

    assign beat_ready_o = ~valid_q | chunk_ready_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else if (beat_ready_o) begin
            valid_q <= beat_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (beat_ready_o && beat_valid_i) begin
            chunk_q <= chunk_d;
        end
    end

    assign chunk_valid_o = valid_q;
    assign chunk_o       = chunk_q;

endmodule

`default_nettype wire

//--- rtl/sld_assemble.sv
//////////////////////////////////////////////////////////////////////
// slide result assembly
// collects chunks, applies the vl mask, sends under credit control
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module sld_assemble #(
    parameter int unsigned NUM_CREDITS = 2
) (
    input  wire logic                 clk_i,
    input  wire logic                 async_rst_ni,
    input  wire logic                 chunk_valid_i,
    input  wire sld_pkg::sld_chunk_t  chunk_i,
    input  wire logic                 credit_i,
    output logic                      chunk_ready_o,
    output logic                      res_valid_o,
    output sld_pkg::sld_result_t      res_o
);

    localparam int VREG_W      = sld_pkg::VREG_W;
    localparam int SLD_OP_W    = sld_pkg::SLD_OP_W;
    localparam int VREG_BYTES  = sld_pkg::VREG_BYTES;
    localparam int CHUNK_BYTES = sld_pkg::CHUNK_BYTES;
    localparam int CRED_W      = $clog2(NUM_CREDITS + 1);

    logic [VREG_W-1:0]      vd_q;       // destination shift register
    logic [VREG_BYTES-1:0]  msk_q;
    logic                   full_q;     // shift register holds a whole vector
    logic                   res_vld_q;
    sld_pkg::sld_result_t   res_q;
    logic [CRED_W-1:0]      cred_q;
    logic [CHUNK_BYTES-1:0] vl_msk;
    logic [7:0]             vl_bytes;
    logic                   take;
    logic                   move;
    logic                   send;

    ///////////////////////////////////////////////////////////////////
    // vector length mask for this chunk

    always_comb begin
        vl_bytes = {3'b0, chunk_i.vl} * {5'b0, sld_pkg::eew_bytes(chunk_i.eew)};
        for (int k = 0; k < CHUNK_BYTES; k++) begin
            vl_msk[k] = (8'(chunk_i.idx) * 8'(CHUNK_BYTES) + 8'(k)) < vl_bytes;
        end
    end

    assign send          = res_vld_q & (cred_q != '0);
    assign move          = full_q & (~res_vld_q | send);
    assign chunk_ready_o = ~full_q | move;
    assign take          = chunk_valid_i & chunk_ready_o;

    ///////////////////////////////////////////////////////////////////
    // control and credits

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            full_q    <= 1'b0;
            res_vld_q <= 1'b0;
            cred_q    <= CRED_W'(NUM_CREDITS);
        end else begin
            if (take) begin
                full_q <= chunk_i.last;
            end else if (move) begin
                full_q <= 1'b0;
            end

            if (move) begin
                res_vld_q <= 1'b1;
            end else if (send) begin
                res_vld_q <= 1'b0;
            end

            case ({credit_i, send})
                2'b10:   cred_q <= cred_q + CRED_W'(1);
                2'b01:   cred_q <= cred_q - CRED_W'(1);
                default: cred_q <= cred_q;     // return and spend cancel
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            vd_q  <= {chunk_i.data, vd_q[VREG_W-1:SLD_OP_W]};
            msk_q <= {chunk_i.bvld & vl_msk, msk_q[VREG_BYTES-1:CHUNK_BYTES]};
        end
        if (move) begin
            res_q.data <= vd_q;
            res_q.be   <= msk_q;
        end
    end

    assign res_valid_o = send;
    assign res_o       = res_q;

endmodule

`default_nettype wire

//--- rtl/sld_unit.sv
//////////////////////////////////////////////////////////////////////
// vector slide unit top level
// issue, operand, shift and assembly stages in a chain
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module sld_unit #(
    parameter int unsigned NUM_CREDITS = 2
) (
    input  wire logic                 clk_i,
    input  wire logic                 async_rst_ni,
    input  wire logic                 cmd_valid_i,
    input  wire sld_pkg::sld_cmd_t    cmd_i,
    output logic                      cmd_ready_o,
    output logic                      res_valid_o,
    output sld_pkg::sld_result_t      res_o,
    input  wire logic                 credit_i
);

    logic                iss_valid;
    logic                iss_ready;
    sld_pkg::sld_beat_t  iss_beat;
    logic                opd_valid;
    logic                opd_ready;
    sld_pkg::sld_beat_t  opd_beat;
    logic                shf_valid;
    logic                shf_ready;
    sld_pkg::sld_chunk_t shf_chunk;

    sld_issue u_issue (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_i        (cmd_i),
        .beat_ready_i (iss_ready),
        .cmd_ready_o  (cmd_ready_o),
        .beat_valid_o (iss_valid),
        .beat_o       (iss_beat)
    );

    sld_operand u_operand (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .beat_valid_i (iss_valid),
        .beat_i       (iss_beat),
        .beat_ready_i (opd_ready),
        .beat_ready_o (iss_ready),
        .beat_valid_o (opd_valid),
        .beat_o       (opd_beat)
    );

    sld_shift u_shift (
        .clk_i         (clk_i),
        .async_rst_ni  (async_rst_ni),
        .beat_valid_i  (opd_valid),
        .beat_i        (opd_beat),
        .chunk_ready_i (shf_ready),
        .beat_ready_o  (opd_ready),
        .chunk_valid_o (shf_valid),
        .chunk_o       (shf_chunk)
    );

    sld_assemble #(
        .NUM_CREDITS (NUM_CREDITS)
    ) u_assemble (
        .clk_i         (clk_i),
        .async_rst_ni  (async_rst_ni),
        .chunk_valid_i (shf_valid),
        .chunk_i       (shf_chunk),
        .credit_i      (credit_i),
        .chunk_ready_o (shf_ready),
        .res_valid_o   (res_valid_o),
        .res_o         (res_o)
    );

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
//////////////////////////////////////////////////////////////////////
// testbench clock and reset source
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD     = 100,   // ns
    parameter int RST_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_no <= 1'b1;   // released on a rising edge
    end

endmodule

`default_nettype wire

//--- tests/tb_sld_unit.sv
//////////////////////////////////////////////////////////////////////
// vector slide unit testbench
// table driven commands checked against an element level model
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_sld_unit;

    localparam int NUM_CREDITS   = 2;
    localparam int RST_TIMEOUT   = 50;
    localparam int CMD_TIMEOUT   = 200;
    localparam int RES_TIMEOUT   = 100;
    localparam int DRAIN_TIMEOUT = 2000;
    localparam int BP_CMDS       = 5;

    typedef struct packed {
        sld_pkg::sld_op_e             op;
        sld_pkg::sld_eew_e            eew;
        logic [sld_pkg::OFFSET_W-1:0] offset;
        logic [sld_pkg::VL_W-1:0]     vl;
        logic [31:0]                  scalar;
    } stim_t;

    logic                 clk;
    logic                 rst_n;
    logic                 cmd_valid;
    sld_pkg::sld_cmd_t    cmd;
    logic                 cmd_ready;
    logic                 res_valid;
    sld_pkg::sld_result_t res;
    logic                 credit;

    stim_t                stim_q[$];
    string                test_names[$];
    sld_pkg::sld_result_t exp_q[$];
    string                exp_names[$];
    int                   mismatches   = 0;
    int                   timeouts     = 0;
    int                   other_errors = 0;
    int                   res_seen     = 0;
    int                   credits_owed = 0;
    bit                   auto_credit  = 1'b1;   // hand each credit back after a result

    tb_clk_gen #(.PERIOD(100), .RST_CYCLES(10)) u_clk_gen (.clk_o(clk), .rst_no(rst_n));

    sld_unit #(
        .NUM_CREDITS (NUM_CREDITS)
    ) u_dut (
        .clk_i        (clk),
        .async_rst_ni (rst_n),
        .cmd_valid_i  (cmd_valid),
        .cmd_i        (cmd),
        .cmd_ready_o  (cmd_ready),
        .res_valid_o  (res_valid),
        .res_o        (res),
        .credit_i     (credit)
    );

    ///////////////////////////////////////////////////////////////////
    // reference model

    function automatic int width_in_bytes(sld_pkg::sld_eew_e eew);
        if (eew == sld_pkg::EEW_16) return 2;
        if (eew == sld_pkg::EEW_32) return 4;
        return 1;
    endfunction

    // element j of the source or zero outside the register
    function automatic logic [31:0] elem_of(logic [127:0] src, int j, int eb);
        logic [31:0] v;
        v = '0;
        if (j >= 0 && j * eb < sld_pkg::VREG_BYTES) begin
            for (int b = 0; b < eb; b++) v[b*8 +: 8] = src[(j*eb + b)*8 +: 8];
        end
        return v;
    endfunction

    task automatic predict(input sld_pkg::sld_cmd_t c, output sld_pkg::sld_result_t r);
        int          eb;
        int          nel;
        int          off;
        int          vl;
        logic [31:0] val;
        logic        wr;
        r   = '0;
        eb  = width_in_bytes(c.eew);
        nel = sld_pkg::VREG_BYTES / eb;
        off = c.offset;
        vl  = c.vl;
        for (int i = 0; i < nel; i++) begin
            wr  = 1'b1;
            val = '0;
            case (c.op)
                sld_pkg::SLD_UP: begin
                    wr = (i >= off);                  // low elements stay untouched
                    if (wr) val = elem_of(c.src, i - off, eb);
                end
                sld_pkg::SLD_DOWN: val = elem_of(c.src, i + off, eb);
                sld_pkg::SLD_1UP:  val = (i == 0) ? c.scalar : elem_of(c.src, i - 1, eb);
                default:           val = (i == vl - 1) ? c.scalar : elem_of(c.src, i + 1, eb);
            endcase
            if (i >= vl) wr = 1'b0;                   // tail
            if (wr) begin
                for (int b = 0; b < eb; b++) begin
                    r.data[(i*eb + b)*8 +: 8] = val[b*8 +: 8];
                    r.be[i*eb + b]            = 1'b1;
                end
            end
        end
    endtask

    ///////////////////////////////////////////////////////////////////
    // stimulus table and helpers

    function automatic void add_entry(input string name, input sld_pkg::sld_op_e op,
                                      input sld_pkg::sld_eew_e eew, input int offset,
                                      input int vl, input logic [31:0] scalar);
        stim_t s;
        s.op     = op;
        s.eew    = eew;
        s.offset = offset[sld_pkg::OFFSET_W-1:0];
        s.vl     = vl[sld_pkg::VL_W-1:0];
        s.scalar = scalar;
        stim_q.push_back(s);
        test_names.push_back(name);
    endfunction

    function automatic sld_pkg::sld_cmd_t make_cmd(int t);
        sld_pkg::sld_cmd_t c;
        c.op     = stim_q[t].op;
        c.eew    = stim_q[t].eew;
        c.offset = stim_q[t].offset;
        c.vl     = stim_q[t].vl;
        c.scalar = stim_q[t].scalar;
        c.src    = {$urandom(), $urandom(), $urandom(), $urandom()};
        return c;
    endfunction

    task automatic end_run();
        $display("error counts: %0d mismatches, %0d timeouts, %0d other",
                 mismatches, timeouts, other_errors);
        if (mismatches + timeouts + other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("TIMEOUT: gave up waiting for %s", what);
        end_run();
    endtask

    // called on a rising edge and returns on the edge that transfers the command
    task automatic issue_cmd(input sld_pkg::sld_cmd_t c, input string name);
        sld_pkg::sld_result_t exp;
        int                   wait_cnt;
        bit                   accepted;
        predict(c, exp);
        exp_q.push_back(exp);
        exp_names.push_back(name);
        cmd_valid <= 1'b1;
        cmd       <= c;
        wait_cnt  = 0;
        accepted  = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            if (cmd_ready === 1'b1) begin
                accepted = 1'b1;
            end else begin
                wait_cnt++;
                if (wait_cnt > CMD_TIMEOUT) report_timeout({"cmd_ready on ", name});
            end
            @(posedge clk);
        end
    endtask

    task automatic wait_drain();
        int wait_cnt;
        wait_cnt = 0;
        while (exp_q.size() > 0) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > DRAIN_TIMEOUT) report_timeout("the outstanding results");
        end
    endtask

    task automatic check_result();
        sld_pkg::sld_result_t exp;
        string                name;
        logic [127:0]         dmask;
        assert (exp_q.size() > 0) else begin
            other_errors++;
            $display("ERROR: a result came out with no command outstanding");
        end
        if (exp_q.size() > 0) begin
            exp  = exp_q.pop_front();
            name = exp_names.pop_front();
            for (int k = 0; k < sld_pkg::VREG_BYTES; k++) dmask[k*8 +: 8] = {8{exp.be[k]}};
            assert (res.be === exp.be && (res.data & dmask) === (exp.data & dmask)) else begin
                mismatches++;
                $display("MISMATCH %s: expected data=%h be=%h, actual data=%h be=%h",
                         name, exp.data & dmask, exp.be, res.data & dmask, res.be);
            end
        end
    endtask

    ///////////////////////////////////////////////////////////////////
    // result monitor and credit return

    always @(negedge clk) begin
        if (res_valid === 1'b1) begin
            res_seen = res_seen + 1;
            if (auto_credit) credits_owed = credits_owed + 1;
            check_result();
        end
    end

    always @(posedge clk) begin
        if (credits_owed > 0) begin
            credit       <= 1'b1;   // one credit per high cycle
            credits_owed = credits_owed - 1;
        end else begin
            credit <= 1'b0;
        end
    end

    ///////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        int unsigned seed;
        int          wait_cnt;
        int          lat;
        cmd_valid = 1'b0;
        cmd       = '0;
        credit    = 1'b0;
        seed      = $urandom(32'h3108_98a4);

        add_entry("up8_ofs0",   sld_pkg::SLD_UP,    sld_pkg::EEW_8,  0, 16, 32'h0);
        add_entry("up8_ofs1",   sld_pkg::SLD_UP,    sld_pkg::EEW_8,  1, 16, 32'h0);
        add_entry("up8_ofs6",   sld_pkg::SLD_UP,    sld_pkg::EEW_8,  6, 16, 32'h0);
        add_entry("up8_ofs20",  sld_pkg::SLD_UP,    sld_pkg::EEW_8,  20, 16, 32'h0);
        add_entry("up16_ofs0",  sld_pkg::SLD_UP,    sld_pkg::EEW_16, 0, 8, 32'h0);
        add_entry("up16_ofs1",  sld_pkg::SLD_UP,    sld_pkg::EEW_16, 1, 8, 32'h0);
        add_entry("up16_ofs3",  sld_pkg::SLD_UP,    sld_pkg::EEW_16, 3, 8, 32'h0);
        add_entry("up16_ofs40", sld_pkg::SLD_UP,    sld_pkg::EEW_16, 40, 8, 32'h0);
        add_entry("up32_ofs0",  sld_pkg::SLD_UP,    sld_pkg::EEW_32, 0, 4, 32'h0);
        add_entry("up32_ofs1",  sld_pkg::SLD_UP,    sld_pkg::EEW_32, 1, 4, 32'h0);
        add_entry("up32_ofs2",  sld_pkg::SLD_UP,    sld_pkg::EEW_32, 2, 4, 32'h0);
        add_entry("up32_ofs63", sld_pkg::SLD_UP,    sld_pkg::EEW_32, 63, 4, 32'h0);
        add_entry("dn8_ofs0",   sld_pkg::SLD_DOWN,  sld_pkg::EEW_8,  0, 16, 32'h0);
        add_entry("dn8_ofs7",   sld_pkg::SLD_DOWN,  sld_pkg::EEW_8,  7, 16, 32'h0);
        add_entry("dn8_ofs16",  sld_pkg::SLD_DOWN,  sld_pkg::EEW_8,  16, 16, 32'h0);
        add_entry("dn16_ofs1",  sld_pkg::SLD_DOWN,  sld_pkg::EEW_16, 1, 8, 32'h0);
        add_entry("dn16_ofs5",  sld_pkg::SLD_DOWN,  sld_pkg::EEW_16, 5, 8, 32'h0);
        add_entry("dn32_ofs3",  sld_pkg::SLD_DOWN,  sld_pkg::EEW_32, 3, 4, 32'h0);
        add_entry("dn32_ofs63", sld_pkg::SLD_DOWN,  sld_pkg::EEW_32, 63, 4, 32'h0);
        add_entry("s1up8",      sld_pkg::SLD_1UP,   sld_pkg::EEW_8,  3, 16, 32'h1234_56a7);
        add_entry("s1up16",     sld_pkg::SLD_1UP,   sld_pkg::EEW_16, 0, 8, 32'hbeef_c0de);
        add_entry("s1up32",     sld_pkg::SLD_1UP,   sld_pkg::EEW_32, 0, 4, 32'h8765_4321);
        add_entry("s1dn8",      sld_pkg::SLD_1DOWN, sld_pkg::EEW_8,  2, 11, 32'hdead_be5a);
        add_entry("s1dn16",     sld_pkg::SLD_1DOWN, sld_pkg::EEW_16, 0, 8, 32'h0f1e_2d3c);
        add_entry("s1dn32",     sld_pkg::SLD_1DOWN, sld_pkg::EEW_32, 0, 3, 32'hc001_d00d);
        add_entry("vl0_up8",    sld_pkg::SLD_UP,    sld_pkg::EEW_8,  2, 0, 32'h0);
        add_entry("vl0_dn32",   sld_pkg::SLD_DOWN,  sld_pkg::EEW_32, 1, 0, 32'h0);
        add_entry("vl0_s1dn16", sld_pkg::SLD_1DOWN, sld_pkg::EEW_16, 0, 0, 32'h5555_aaaa);
        add_entry("vl5_up16",   sld_pkg::SLD_UP,    sld_pkg::EEW_16, 1, 5, 32'h0);
        add_entry("vl9_dn8",    sld_pkg::SLD_DOWN,  sld_pkg::EEW_8,  2, 9, 32'h0);

        wait_cnt = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > RST_TIMEOUT) report_timeout("reset release");
        end
        @(negedge clk);
        assert (res_valid === 1'b0 && cmd_ready === 1'b1) else begin
            other_errors++;
            $display("ERROR: after reset res_valid=%b cmd_ready=%b", res_valid, cmd_ready);
        end

        // single command to measure latency without back-pressure
        @(posedge clk);
        issue_cmd(make_cmd(0), test_names[0]);
        cmd_valid <= 1'b0;
        lat = 0;
        @(negedge clk);
        while (res_valid !== 1'b1) begin
            lat++;
            if (lat > RES_TIMEOUT) report_timeout("the first result");
            @(negedge clk);
        end
        assert (lat == sld_pkg::CHUNK_CNT + 3) else begin
            mismatches++;
            $display("MISMATCH latency: expected %0d, actual %0d", sld_pkg::CHUNK_CNT + 3, lat);
        end
        wait_drain();

        // whole table back to back
        @(posedge clk);
        for (int t = 0; t < stim_q.size(); t++) issue_cmd(make_cmd(t), test_names[t]);
        cmd_valid <= 1'b0;
        wait_drain();

        ///////////////////////////////////////////////////////////////
        // credits withheld and later handed back
        auto_credit = 1'b0;
        res_seen    = 0;
        @(posedge clk);
        fork
            begin
                for (int t = 0; t < BP_CMDS; t++) issue_cmd(make_cmd(t), test_names[t]);
                cmd_valid <= 1'b0;
            end
            begin
                wait_cnt = 0;
                while (res_seen < NUM_CREDITS) begin
                    @(negedge clk);
                    wait_cnt++;
                    if (wait_cnt > RES_TIMEOUT) report_timeout("results on the initial credits");
                end
                repeat (40) @(negedge clk);    // quiet window while the chain is stalled
                assert (res_seen <= NUM_CREDITS) else begin
                    other_errors++;
                    $display("ERROR: %0d results sent on %0d credits", res_seen, NUM_CREDITS);
                end
                credits_owed = credits_owed + res_seen;
                auto_credit  = 1'b1;
            end
        join
        wait_drain();
        end_run();
    end

endmodule

`default_nettype wire

//--- sources.f
rtl/sld_pkg.sv
rtl/sld_issue.sv
rtl/sld_operand.sv
rtl/sld_shift.sv
rtl/sld_assemble.sv
rtl/sld_unit.sv
tests/tb_clk_gen.sv
tests/tb_sld_unit.sv
